// File: dv/tb_e31x_idle_fabric.sv
`timescale 1ns/1ps
/* Directed and random stimulus against a cycle model of the idle fabric.
   Inputs change on the falling edge and outputs are compared there too. */
module tb_e31x_idle_fabric;
  import e31x_irq_pkg::*;
  import e31x_db_pkg::*;

  // Upper bound on any wait, in cycles
  localparam int WAIT_LIMIT = 100;
  // Vector bits with no source
  localparam logic [15:0] UNUSED_IRQ = 16'hFFC1;

  logic        bus_clk;
  logic        bus_rst;
  // Board inputs as {pmu, ext pps, gps pps, power switch}
  logic [3:0]  board_in;
  logic [15:0] irq_f2p;
  logic        ps_gpio_pps;
  logic [99:0] db_out;
  logic [99:0] db_oe;

  int   seed;
  int   hold_left [4];
  int   value_errors = 0;
  int   other_errors = 0;
  logic compare_on;

  // Model state
  logic [3:0]               m_s1;
  logic [3:0]               m_s2;
  logic [3:0]               m_h0;
  logic [3:0]               m_h1;
  logic [NUM_EVT-1:0]       m_strobe;
  int unsigned              m_cnt [NUM_EVT];
  logic [IRQ_WIDTH-1:0]     m_irq;
  logic                     m_gpio;
  logic [NUM_DB_IO_PINS-1:0] m_out;
  logic [NUM_DB_IO_PINS-1:0] m_oe;
  // Stimulus coverage
  int evt_seen [NUM_EVT];
  int retrig_count = 0;

  e31x_idle_fabric dut (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (board_in[0]),
    .gps_pps     (board_in[1]),
    .pps_ext_in  (board_in[2]),
    .pmu_irq     (board_in[3]),
    .irq_f2p     (irq_f2p),
    .ps_gpio_pps (ps_gpio_pps),
    .db_out      (db_out),
    .db_oe       (db_oe)
  );

  always #10 bus_clk = ~bus_clk;

  //////////////////////////////////////////////////
  // Cycle model
  //////////////////////////////////////////////////

  always @(posedge bus_clk) begin : model_step
    logic [IRQ_WIDTH-1:0] irq_next;
    int k;
    if (bus_rst) begin
      // Switch idles high, the rest low
      m_s1     <= 4'b0001;
      m_s2     <= 4'b0001;
      m_h0     <= 4'b0001;
      m_h1     <= 4'b0001;
      m_strobe <= '0;
      for (k = 0; k < NUM_EVT; k++) m_cnt[k] <= 0;
      m_irq    <= '0;
      m_gpio   <= 1'b0;
      m_out    <= '0;
      m_oe     <= '0;
    end else begin
      m_s1 <= board_in;
      m_s2 <= m_s1;
      m_h0 <= m_s2;
      m_h1 <= m_h0;
      // New level on stage two, old level twice in history
      m_strobe[EVT_PRESS]   <= !m_s2[0] &&  m_h0[0] &&  m_h1[0];
      m_strobe[EVT_RELEASE] <=  m_s2[0] && !m_h0[0] && !m_h1[0];
      m_strobe[EVT_GPS_PPS] <=  m_s2[1] && !m_h0[1] && !m_h1[1];
      m_strobe[EVT_EXT_PPS] <=  m_s2[2] && !m_h0[2] && !m_h1[2];
      // Stretch window as a reloading down counter
      for (k = 0; k < NUM_EVT; k++) begin
        if (m_strobe[k]) begin
          m_cnt[k] <= STRETCH_LEN;
          evt_seen[k]++;
          if (m_cnt[k] != 0) retrig_count++;
        end else if (m_cnt[k] != 0) begin
          m_cnt[k] <= m_cnt[k] - 1;
        end
      end
      irq_next = '0;
      irq_next[IRQ_BIT_PRESS]   = (m_cnt[EVT_PRESS] != 0);
      irq_next[IRQ_BIT_RELEASE] = (m_cnt[EVT_RELEASE] != 0);
      irq_next[IRQ_BIT_GPS_PPS] = (m_cnt[EVT_GPS_PPS] != 0);
      irq_next[IRQ_BIT_EXT_PPS] = (m_cnt[EVT_EXT_PPS] != 0);
      // PMU level from stage two
      irq_next[IRQ_BIT_PMU]     = m_s2[3];
      m_irq  <= irq_next;
      // GPS third stage toward the GPIO
      m_gpio <= m_h0[1];
      m_out  <= DB_IDLE_OUT;
      m_oe   <= DB_IDLE_DDR;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge bus_clk) begin
    if (compare_on) begin
      check_value("irq_f2p", 128'(m_irq), 128'(irq_f2p));
      check_value("ps_gpio_pps", 128'(m_gpio), 128'(ps_gpio_pps));
      check_value("db_out", 128'(m_out), 128'(db_out));
      check_value("db_oe", 128'(m_oe), 128'(db_oe));
      check_value("irq_f2p unused bits", '0, 128'(irq_f2p & UNUSED_IRQ));
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [127:0] exp_val,
                             input logic [127:0] act_val);
    if (act_val !== exp_val) begin
      $display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp_val, act_val);
      value_errors++;
    end
  endtask

  // Hold length of 3 to 20 cycles
  function automatic int random_hold();
    random_hold = 3 + int'($unsigned($random(seed)) % 32'd18);
  endfunction

  task automatic drive_random_cycle();
    int i;
    for (i = 0; i < 4; i++) begin
      hold_left[i]--;
      if (hold_left[i] <= 0) begin
        board_in[i] = ~board_in[i];
        hold_left[i] = random_hold();
      end
    end
  endtask

  // Edge count is taken from the drive, edge 0 samples the new value
  task automatic wait_irq_bit(input logic [3:0] bit_idx, input logic level, input string name,
                              input int exp_edge, output bit seen);
    int edges;
    edges = 0;
    seen = 1'b0;
    while (!seen && edges < WAIT_LIMIT) begin
      @(negedge bus_clk);
      edges++;
      if (irq_f2p[bit_idx] === level) seen = 1'b1;
    end
    if (!seen) begin
      $display("Timeout at %0t ns: %s bit never reached level %0b", $time, name, level);
      other_errors++;
    end else begin
      check_value({name, " edge"}, 128'(exp_edge), 128'(edges - 1));
    end
  endtask

  // Rise at edge 4, then measure the width and watch the partner bit
  task automatic expect_irq_pulse(input logic [3:0] bit_idx, input logic [3:0] other_idx,
                                  input string name, input int exp_width);
    int width;
    int guard;
    bit seen;
    bit other_hit;
    wait_irq_bit(bit_idx, 1'b1, name, 4, seen);
    if (seen) begin
      width = 1;
      guard = 0;
      other_hit = irq_f2p[other_idx];
      while (irq_f2p[bit_idx] && guard < WAIT_LIMIT) begin
        @(negedge bus_clk);
        guard++;
        if (irq_f2p[bit_idx]) width++;
        if (irq_f2p[other_idx]) other_hit = 1'b1;
      end
      if (guard >= WAIT_LIMIT) begin
        $display("Timeout at %0t ns: %s interrupt never dropped", $time, name);
        other_errors++;
      end else begin
        check_value({name, " width"}, 128'(exp_width), 128'(width));
      end
      if (other_hit) begin
        $display("The %s event also raised interrupt bit %0d", name, other_idx);
        other_errors++;
      end
    end
  endtask

  // Falling PPS edges must leave the bit low
  task automatic quiet_window(input logic [3:0] bit_idx, input string name);
    int i;
    for (i = 0; i < 12; i++) begin
      @(negedge bus_clk);
      check_value(name, '0, 128'(irq_f2p[bit_idx]));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    int k;
    bit seen;
    seed       = 32'h087f7a23;
    bus_clk    = 1'b0;
    bus_rst    = 1'b1;
    board_in   = 4'b0001;
    compare_on = 1'b0;
    for (k = 0; k < NUM_EVT; k++) evt_seen[k] = 0;
    for (k = 0; k < 4; k++) hold_left[k] = random_hold();

    // Reset for 3 cycles
    @(posedge bus_clk);
    compare_on = 1'b1;
    repeat (3) @(negedge bus_clk);
    bus_rst = 1'b0;
    repeat (6) @(negedge bus_clk);

    // Power switch press and release
    board_in[0] = 1'b0;
    expect_irq_pulse(IRQ_BIT_PRESS, IRQ_BIT_RELEASE, "press", STRETCH_LEN);
    board_in[0] = 1'b1;
    expect_irq_pulse(IRQ_BIT_RELEASE, IRQ_BIT_PRESS, "release", STRETCH_LEN);

    // PPS rises fire, falls do not
    board_in[1] = 1'b1;
    expect_irq_pulse(IRQ_BIT_GPS_PPS, IRQ_BIT_EXT_PPS, "gps pps", STRETCH_LEN);
    board_in[1] = 1'b0;
    quiet_window(IRQ_BIT_GPS_PPS, "irq_f2p gps bit after fall");
    board_in[2] = 1'b1;
    expect_irq_pulse(IRQ_BIT_EXT_PPS, IRQ_BIT_GPS_PPS, "ext pps", STRETCH_LEN);
    board_in[2] = 1'b0;
    quiet_window(IRQ_BIT_EXT_PPS, "irq_f2p ext bit after fall");

    // Second rise 6 cycles later extends the window
    board_in[1] = 1'b1;
    fork
      begin
        repeat (3) @(negedge bus_clk);
        board_in[1] = 1'b0;
        repeat (3) @(negedge bus_clk);
        board_in[1] = 1'b1;
      end
      expect_irq_pulse(IRQ_BIT_GPS_PPS, IRQ_BIT_EXT_PPS, "gps pps retrigger", STRETCH_LEN + 6);
    join

    // PMU level passes through at edge 2
    board_in[3] = 1'b1;
    wait_irq_bit(IRQ_BIT_PMU, 1'b1, "pmu set", 2, seen);
    board_in[3] = 1'b0;
    wait_irq_bit(IRQ_BIT_PMU, 1'b0, "pmu clear", 2, seen);

    // Channel activity from here on comes from random stimulus alone
    for (k = 0; k < NUM_EVT; k++) evt_seen[k] = 0;
    retrig_count = 0;

    // Random levels, model compared every cycle
    repeat (2000) begin
      @(negedge bus_clk);
      drive_random_cycle();
    end

    // Reset mid-run, pins must release
    @(negedge bus_clk);
    bus_rst = 1'b1;
    @(negedge bus_clk);
    check_value("db_oe during reset", '0, 128'(db_oe));
    repeat (2) @(negedge bus_clk);
    bus_rst = 1'b0;
    repeat (500) begin
      @(negedge bus_clk);
      drive_random_cycle();
    end

    // Stimulus must have reached every channel and a retrigger
    for (k = 0; k < NUM_EVT; k++) begin
      if (evt_seen[k] == 0) begin
        $display("Event channel %0d never fired during the run", k);
        other_errors++;
      end
    end
    if (retrig_count == 0) begin
      $display("No event ever landed inside a stretch window");
      other_errors++;
    end

    $display("Value errors: %0d, other failures: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: logic/e31x_db_pkg.sv
/* Idle daughterboard pin patterns; a 1 in DB_IDLE_DDR means the pin is driven.
   Only the DB_1_8V_2 pin is driven high while idle. */
package e31x_db_pkg;

  // Total daughterboard IO pins
  localparam int unsigned NUM_DB_IO_PINS = 100;

  //////////////////////////////////////////////////
  // Idle output values, MSB first
  //////////////////////////////////////////////////

  localparam logic [NUM_DB_IO_PINS-1:0] DB_IDLE_OUT = {
    1'b0,        // 99     DB_EXP_18_24
    13'h0000,    // 98:86  LEDs and RX band selects
    3'b000,      // 85:83  CAT_FB_CLK, CAT_TX_FRAME, CAT_RX_DATA_CLK
    25'h0000000, // 82:58  CAT_RX_FRAME, CAT_P0 and CAT_P1 data
    1'b0,        // 57     CAT_SYNC
    4'b0000,     // 56:53  CAT_ENAGC, CAT_BBCLK_OUT, CAT_ENABLE, CAT_TXNRX
    3'b000,      // 52:50  DB_EXP_1_8V spares
    2'b00,       // 49:48  CAT_CTRL_IN[1:0]
    1'b0,        // 47     CAT_MISO
    4'b0000,     // 46:43  CAT_MOSI, CAT_SCLK, CAT_CS, CAT_RESETn
    1'b0,        // 42     DB_1_8V_31
    8'h00,       // 41:34  CAT_CTRL_OUT
    4'b0000,     // 33:30  DB_1_8V_11, CAT_CTRL_IN3, DB_1_8V_10, CAT_CTRL_IN2
    4'b0000,     // 29:26  DB_1_8V_9, VCRX2_V2, DB_1_8V_8, VCRX2_V1
    4'b0000,     // 25:22  DB_1_8V_7, VCRX1_V2, DB_1_8V_6, VCRX1_V1
    4'b0000,     // 21:18  DB_1_8V_5, VCTXRX1_V2, DB_1_8V_4, VCTXRX1_V1
    3'b001,      // 17:15  DB_1_8V_3, VCTXRX2_V1, DB_1_8V_2
    15'h0000     // 14:0   unused
  };

  //////////////////////////////////////////////////
  // Idle direction, 1 drives the pin
  //////////////////////////////////////////////////

  localparam logic [NUM_DB_IO_PINS-1:0] DB_IDLE_DDR = {
    1'b0,             // 99     DB_EXP_18_24
    13'b0101010101010, // 98:86  Band selects driven, LEDs floating
    3'b000,           // 85:83  CAT clocks and frame are inputs
    25'h0000000,      // 82:58  CAT data bus left as input
    1'b0,             // 57     CAT_SYNC
    4'b0001,          // 56:53  Only CAT_TXNRX driven
    3'b000,           // 52:50  DB_EXP_1_8V spares
    2'b00,            // 49:48  CAT_CTRL_IN[1:0]
    1'b0,             // 47     CAT_MISO is an input
    4'b0111,          // 46:43  SPI SCLK, CS and RESETn driven
    1'b0,             // 42     DB_1_8V_31
    8'h00,            // 41:34  CAT_CTRL_OUT
    4'b0000,          // 33:30  DB_1_8V_11, CAT_CTRL_IN3, DB_1_8V_10, CAT_CTRL_IN2
    4'b0000,          // 29:26  RX2 switch controls floating
    4'b0000,          // 25:22  RX1 switch controls floating
    4'b0000,          // 21:18  TXRX1 switch controls floating
    3'b101,           // 17:15  DB_1_8V_3 and DB_1_8V_2 driven
    15'h0000          // 14:0   unused
  };

endpackage

// File: logic/e31x_idle_fabric.sv
`timescale 1ns/1ps
/* Idle fabric housekeeping, bus_clk domain only; bus_rst must already be synchronous.
   Pin value and enable come out raw, IO buffers sit outside. */
module e31x_idle_fabric (
  input  logic                                    bus_clk,
  input  logic                                    bus_rst,
  input  logic                                    onswitch_db,
  input  logic                                    gps_pps,
  input  logic                                    pps_ext_in,
  input  logic                                    pmu_irq,
  output logic [e31x_irq_pkg::IRQ_WIDTH-1:0]      irq_f2p,
  output logic                                    ps_gpio_pps,
  output logic [e31x_db_pkg::NUM_DB_IO_PINS-1:0]  db_out,
  output logic [e31x_db_pkg::NUM_DB_IO_PINS-1:0]  db_oe
);
  import e31x_irq_pkg::*;

  // Single-cycle transition strobes
  logic [NUM_EVT-1:0] evt_strobe;
  // Stretched interrupt pulses
  logic [NUM_EVT-1:0] irq_pulse;
  logic               pmu_lvl;
  logic               pps_lvl;

  //////////////////////////////////////////////////
  // Input sync and edge detect
  //////////////////////////////////////////////////

  input_conditioner u_cond (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_db (onswitch_db),
    .gps_pps     (gps_pps),
    .pps_ext_in  (pps_ext_in),
    .pmu_irq     (pmu_irq),
    .evt_strobe  (evt_strobe),
    .pmu_lvl     (pmu_lvl),
    .pps_lvl     (pps_lvl)
  );

  //////////////////////////////////////////////////
  // One stretcher per event channel
  //////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_EVT; k++) begin : g_stretch
    irq_stretcher u_stretch (
      .bus_clk    (bus_clk),
      .bus_rst    (bus_rst),
      .evt_strobe (evt_strobe[k]),
      .irq_pulse  (irq_pulse[k])
    );
  end

  // Vector, PPS GPIO and daughterboard pins
  ps_fabric_port u_port (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .irq_pulse   (irq_pulse),
    .pmu_lvl     (pmu_lvl),
    .pps_lvl     (pps_lvl),
    .irq_f2p     (irq_f2p),
    .ps_gpio_pps (ps_gpio_pps),
    .db_out      (db_out),
    .db_oe       (db_oe)
  );

endmodule

// File: logic/e31x_irq_pkg.sv
/* Event channels and the fabric-to-processor interrupt bit map.
   Vector bits not listed here are tied to zero. */
package e31x_irq_pkg;

  //////////////////////////////////////////////////
  // Event channels
  //////////////////////////////////////////////////

  // Number of stretched event channels
  localparam int unsigned NUM_EVT = 4;

  // Channel indices into the strobe and pulse vectors
  localparam bit [1:0] EVT_PRESS   = 2'd0;
  localparam bit [1:0] EVT_RELEASE = 2'd1;
  localparam bit [1:0] EVT_GPS_PPS = 2'd2;
  localparam bit [1:0] EVT_EXT_PPS = 2'd3;

  // Interrupt pulse length in bus_clk cycles
  // Long enough for the processor GIC to latch it
  localparam int unsigned STRETCH_LEN = 8;

  //////////////////////////////////////////////////
  // Interrupt vector layout
  //////////////////////////////////////////////////

  // Width of IRQ_F2P on the processor block
  localparam int unsigned IRQ_WIDTH = 16;

  // Bit 0 reserved, always zero
  // Power button pressed (switch went low)
  localparam bit [3:0] IRQ_BIT_PRESS   = 4'd1;

  // Power button released
  localparam bit [3:0] IRQ_BIT_RELEASE = 4'd2;

  // PMU interrupt, passed as a level, not stretched
  localparam bit [3:0] IRQ_BIT_PMU     = 4'd3;

  // Rising edge of GPS PPS
  localparam bit [3:0] IRQ_BIT_GPS_PPS = 4'd4;

  // Rising edge of external PPS
  localparam bit [3:0] IRQ_BIT_EXT_PPS = 4'd5;

  // Bits 6 to 15 unused

endpackage

// File: logic/input_conditioner.sv
`timescale 1ns/1ps
/* Inputs are asynchronous levels and each must hold 3 or more bus_clk cycles
   per level, else a transition can be missed. onswitch_db is active low. */
module input_conditioner (
  input  logic                             bus_clk,
  input  logic                             bus_rst,
  input  logic                             onswitch_db,
  input  logic                             gps_pps,
  input  logic                             pps_ext_in,
  input  logic                             pmu_irq,
  output logic [e31x_irq_pkg::NUM_EVT-1:0] evt_strobe,
  output logic                             pmu_lvl,
  output logic                             pps_lvl
);
  import e31x_irq_pkg::*;

  // Raw board inputs as {pmu, ext pps, gps pps, power switch}
  logic [3:0] raw_in;
  // Two-flop synchronizer
  logic [3:0] sync_s1;
  logic [3:0] sync_s2;
  // History for the three edge-detected inputs only
  logic [2:0] hist_0;
  logic [2:0] hist_1;
  logic [NUM_EVT-1:0] evt_next;

  assign raw_in = {pmu_irq, pps_ext_in, gps_pps, onswitch_db};

  //////////////////////////////////////////////////
  // Synchronizers and history
  //////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // Inactive levels, switch idles high
      sync_s1 <= 4'b0001;
      sync_s2 <= 4'b0001;
      hist_0  <= 3'b001;
      hist_1  <= 3'b001;
    end else begin
      sync_s1 <= raw_in;
      sync_s2 <= sync_s1;
      hist_0  <= sync_s2[2:0];
      hist_1  <= hist_0;
    end
  end

  //////////////////////////////////////////////////
  // Transition detect
  //////////////////////////////////////////////////

  // New level on stage two, old level on both history bits
  always_comb begin
    evt_next = '0;
    // Press is the falling edge of the active-low switch
    evt_next[EVT_PRESS]   = ~sync_s2[0] &  hist_0[0] &  hist_1[0];
    evt_next[EVT_RELEASE] =  sync_s2[0] & ~hist_0[0] & ~hist_1[0];
    // Both PPS sources fire on the rise only
    evt_next[EVT_GPS_PPS] =  sync_s2[1] & ~hist_0[1] & ~hist_1[1];
    evt_next[EVT_EXT_PPS] =  sync_s2[2] & ~hist_0[2] & ~hist_1[2];
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      evt_strobe <= '0;
    end else begin
      evt_strobe <= evt_next;
    end
  end

  // PMU level straight off stage two
  assign pmu_lvl = sync_s2[3];
  // GPS PPS third stage for the GPIO path
  assign pps_lvl = hist_0[1];

  // One switch transition never yields both events
  a_press_release_excl : assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(evt_strobe[EVT_PRESS] && evt_strobe[EVT_RELEASE]))
    else $error("press and release strobed together");

endmodule

// File: logic/irq_stretcher.sv
`timescale 1ns/1ps
/* Pulse stays high STRETCH_LEN cycles after the last strobe.
   A strobe inside the window extends it, so back-to-back events merge. */
module irq_stretcher (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic evt_strobe,
  output logic irq_pulse
);
  import e31x_irq_pkg::*;

  // One bit per cycle of the window
  logic [STRETCH_LEN-1:0] hold_sr;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      hold_sr <= '0;
    end else begin
      // Newest strobe enters at bit 0
      hold_sr <= {hold_sr[STRETCH_LEN-2:0], evt_strobe};
    end
  end

  // Any strobe still in the window keeps the pulse up
  assign irq_pulse = |hold_sr;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Window closes STRETCH_LEN cycles after the last strobe
  a_window_closes : assert property (@(posedge bus_clk) disable iff (bus_rst)
    evt_strobe ##1 (!evt_strobe) [*STRETCH_LEN] |=> !irq_pulse)
    else $error("irq_pulse held past the stretch window");

endmodule

// File: logic/ps_fabric_port.sv
`timescale 1ns/1ps
/* Registered drain toward the processor and the daughterboard pins.
   All pins stay tri-stated while bus_rst is high. */
module ps_fabric_port (
  input  logic                                    bus_clk,
  input  logic                                    bus_rst,
  input  logic [e31x_irq_pkg::NUM_EVT-1:0]        irq_pulse,
  input  logic                                    pmu_lvl,
  input  logic                                    pps_lvl,
  output logic [e31x_irq_pkg::IRQ_WIDTH-1:0]      irq_f2p,
  output logic                                    ps_gpio_pps,
  output logic [e31x_db_pkg::NUM_DB_IO_PINS-1:0]  db_out,
  output logic [e31x_db_pkg::NUM_DB_IO_PINS-1:0]  db_oe
);
  import e31x_irq_pkg::*;
  import e31x_db_pkg::*;

  logic [IRQ_WIDTH-1:0] irq_vec;

  //////////////////////////////////////////////////
  // Interrupt vector packing
  //////////////////////////////////////////////////

  always_comb begin
    // Unmapped bits stay zero
    irq_vec = '0;
    irq_vec[IRQ_BIT_PRESS]   = irq_pulse[EVT_PRESS];
    irq_vec[IRQ_BIT_RELEASE] = irq_pulse[EVT_RELEASE];
    irq_vec[IRQ_BIT_GPS_PPS] = irq_pulse[EVT_GPS_PPS];
    irq_vec[IRQ_BIT_EXT_PPS] = irq_pulse[EVT_EXT_PPS];
    // PMU is a level, the processor clears it at the source
    irq_vec[IRQ_BIT_PMU]     = pmu_lvl;
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      irq_f2p     <= '0;
      ps_gpio_pps <= 1'b0;
      // Nothing drives while the board settles
      db_out      <= '0;
      db_oe       <= '0;
    end else begin
      irq_f2p     <= irq_vec;
      // PPS back to the processor GPIO for timekeeping
      ps_gpio_pps <= pps_lvl;
      db_out      <= DB_IDLE_OUT;
      db_oe       <= DB_IDLE_DDR;
    end
  end

  // Pins released the cycle after any reset cycle
  a_db_tristate : assert property (@(posedge bus_clk)
    bus_rst |=> (db_oe == '0))
    else $error("db_oe active right after reset");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator and run; the result is taken from the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_e31x_idle_fabric -f src.f \
  && ./obj_dir/Vtb_e31x_idle_fabric | tee /dev/stderr | grep -F "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: src.f
logic/e31x_irq_pkg.sv
logic/e31x_db_pkg.sv
logic/input_conditioner.sv
logic/irq_stretcher.sv
logic/ps_fabric_port.sv
logic/e31x_idle_fabric.sv
dv/tb_e31x_idle_fabric.sv
